/* common/bus_pkg.sv */
// bus types shared by every block; one flat 28-bit space, top nibble picks the peripheral, no wait states
`default_nettype none

package bus_pkg;

    localparam int BUS_ADDR_W   = 28;                  // full bus address width
    localparam int BUS_DATA_W   = 32;                  // read and write data width
    localparam int BUS_BE_W     = BUS_DATA_W / 8;      // one write enable per byte
    localparam int PERIPH_OFS_W = 24;                  // local offset inside a peripheral

    localparam logic [3:0] PERIPH_PLIC_BASE  = 4'h0;   // addr[27:24] of the interrupt controller
    localparam logic [3:0] PERIPH_TIMER_BASE = 4'h1;   // addr[27:24] of the interval timer

    // one request per cycle, there is no handshake back to the master
    typedef struct packed {
        logic                  en;                     // strobe, valid for this cycle only
        logic [BUS_BE_W-1:0]   we;                     // byte write enables, all zero is a read
        logic [BUS_ADDR_W-1:0] addr;                   // byte address
        logic [BUS_DATA_W-1:0] wdata;                  // write data, ignored on reads
    } bus_req_t;

    typedef enum logic [1:0] {
        SEL_PLIC  = 2'd0,                              // controller answers
        SEL_TIMER = 2'd1,                              // timer answers
        SEL_NONE  = 2'd2                               // unmapped, reads as zero
    } periph_sel_e;

    // merges the written bytes into the current register value
    function automatic logic [BUS_DATA_W-1:0] be_merge(
        input logic [BUS_DATA_W-1:0] cur,
        input logic [BUS_DATA_W-1:0] wdata,
        input logic [BUS_BE_W-1:0]   be
    );
        logic [BUS_DATA_W-1:0] res;
        res = cur;                                     // bytes without enable keep their value
        for (int b = 0; b < BUS_BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];       // take the new byte
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* common/irq_pkg.sv */
// interrupt map for one fixed build of four sources; timer channels are sources 1 and 2, pins 3 and 4
`default_nettype none

package irq_pkg;

    localparam int IRQ_CNT     = 4;                    // sources, numbered 1 to IRQ_CNT
    localparam int IRQ_ID_W    = $clog2(IRQ_CNT + 1);  // holds 0 (none) up to IRQ_CNT
    localparam int TMR_CH_CNT  = 2;                    // timer channels
    localparam int EXT_IRQ_CNT = IRQ_CNT - TMR_CH_CNT; // external level pins

    typedef logic [IRQ_ID_W-1:0] irq_id_t;             // 0 means no interrupt

    localparam irq_id_t TMR_IRQ_BASE = irq_id_t'(1);   // source ID of timer channel 0

    localparam logic [23:0] PLIC_ID_ADDR = 24'h200004; // claim on read, acknowledge on write
    localparam logic [23:0] PLIC_IP_ADDR = 24'h001000; // pending, source n at bit n
    localparam logic [23:0] PLIC_IE_ADDR = 24'h002000; // enable, source n at bit n

    typedef enum logic [23:0] {
        TMR_CTRL    = 24'h000000,                      // bit c enables channel c
        TMR_RELOAD0 = 24'h000004,                      // start value of channel 0
        TMR_RELOAD1 = 24'h000008,                      // start value of channel 1
        TMR_COUNT0  = 24'h000010,                      // live counter 0, read only
        TMR_COUNT1  = 24'h000014                       // live counter 1, read only
    } tmr_reg_e;

endpackage

`default_nettype wire

/* hdl/periph_decoder.sv */
// read data comes from the peripheral's own output register, so rdata_o is valid one cycle after the strobe
`timescale 1ns/10ps
`default_nettype none

module periph_decoder
    import bus_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_n,

    input  wire bus_req_t              bus_i,          // request from the master
    output bus_req_t                   plic_bus_o,     // request seen by the controller
    output bus_req_t                   tmr_bus_o,      // request seen by the timer

    input  wire logic [BUS_DATA_W-1:0] plic_rdata_i,   // registered controller read data
    input  wire logic [BUS_DATA_W-1:0] tmr_rdata_i,    // registered timer read data
    output logic [BUS_DATA_W-1:0]      rdata_o         // read data back to the master
);

    periph_sel_e sel;                                  // target of the current request
    periph_sel_e rd_sel_q;                             // target of the last read
    logic        rd_strobe;                            // read request this cycle

    always_comb begin
        unique case (bus_i.addr[BUS_ADDR_W-1:PERIPH_OFS_W])
            PERIPH_PLIC_BASE:  sel = SEL_PLIC;         // controller window
            PERIPH_TIMER_BASE: sel = SEL_TIMER;        // timer window
            default:           sel = SEL_NONE;         // nothing mapped there
        endcase
    end

    // the address goes through whole, each peripheral only looks at its offset bits
    always_comb begin
        plic_bus_o    = bus_i;
        plic_bus_o.en = bus_i.en && (sel == SEL_PLIC);  // strobe only to the addressed block
        tmr_bus_o     = bus_i;
        tmr_bus_o.en  = bus_i.en && (sel == SEL_TIMER);
    end

    assign rd_strobe = bus_i.en && (bus_i.we == '0);   // writes get no response

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_sel_q <= SEL_NONE;                      // rdata_o is zero out of reset
        end else if (rd_strobe) begin
            rd_sel_q <= sel;                           // held until the next read
        end
    end

    // both inputs are registers that only move on their own reads, so the result holds
    always_comb begin
        unique case (rd_sel_q)
            SEL_PLIC:  rdata_o = plic_rdata_i;
            SEL_TIMER: rdata_o = tmr_rdata_i;
            default:   rdata_o = '0;                   // unmapped reads return zero
        endcase
    end

endmodule

`default_nettype wire

/* plic/plic.sv */
// no priorities, no threshold and one hart; the lowest enabled pending source wins
`timescale 1ns/10ps
`default_nettype none

module plic
    import bus_pkg::*, irq_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_n,

    input  wire bus_req_t              bus_i,          // already gated by the decoder
    output logic [BUS_DATA_W-1:0]      rdata_o,        // registered read data

    input  wire logic [IRQ_CNT-1:0]    irq_i,          // source levels, bit 0 is source 1
    input  wire logic                  iack_i,         // core claims the current winner
    output logic [IRQ_CNT-1:0]         iack_o,         // one-cycle acknowledge per source
    output logic                       irq_o           // request level to the core
);

    logic [IRQ_CNT-1:0]      ip_q;                     // pending, a delayed copy of the levels
    logic [IRQ_CNT-1:0]      ie_q;                     // enable mask
    logic [IRQ_CNT-1:0]      active;                   // enabled and pending
    irq_id_t                 id_win;                   // winner of the search this cycle
    irq_id_t                 id_q;                     // claimed ID

    logic [PERIPH_OFS_W-1:0] ofs;                      // local register offset
    logic                    rd_en;                    // read strobe
    logic                    wr_en;                    // write strobe
    logic [BUS_DATA_W-1:0]   reg_val;                  // addressed register, zero extended
    logic [BUS_DATA_W-1:0]   write_val;                // reg_val with the written bytes merged
    irq_id_t                 wr_id;                    // ID written to the claim register
    logic [IRQ_CNT-1:0]      ack_next;                 // acknowledge decoded from wr_id

    // pending

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ip_q <= '0;
        end else begin
            ip_q <= irq_i;                             // level sources, no edge capture
        end
    end

    assign active = ip_q & ie_q;
    assign irq_o  = |active;                           // combinational, falls as soon as ip drops

    // walk downward so the last hit is the lowest source number
    always_comb begin
        id_win = '0;                                   // zero when nothing is active
        for (int i = IRQ_CNT - 1; i >= 0; i--) begin
            if (active[i]) begin
                id_win = irq_id_t'(i + 1);             // source numbers start at 1
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_q <= '0;
        end else if (iack_i) begin
            id_q <= id_win;                            // may be 0 if the source went away
        end
    end

    // register access

    assign ofs   = bus_i.addr[PERIPH_OFS_W-1:0];
    assign rd_en = bus_i.en && (bus_i.we == '0);
    assign wr_en = bus_i.en && (bus_i.we != '0);

    always_comb begin
        unique case (ofs)
            PLIC_ID_ADDR: reg_val = {{(BUS_DATA_W - IRQ_ID_W){1'b0}}, id_q};
            PLIC_IP_ADDR: reg_val = {{(BUS_DATA_W - IRQ_CNT - 1){1'b0}}, ip_q, 1'b0};
            PLIC_IE_ADDR: reg_val = {{(BUS_DATA_W - IRQ_CNT - 1){1'b0}}, ie_q, 1'b0};
            default:      reg_val = '0;                // unmapped offsets read as zero
        endcase
    end

    assign write_val = be_merge(reg_val, bus_i.wdata, bus_i.we);
    assign wr_id     = write_val[IRQ_ID_W-1:0];         // only the low bits carry an ID

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata_o <= '0;
        end else if (rd_en) begin
            rdata_o <= reg_val;                        // kept until the next read here
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ie_q <= '0;                                // everything masked out of reset
        end else if (wr_en && (ofs == PLIC_IE_ADDR)) begin
            ie_q <= write_val[IRQ_CNT:1];              // bit 0 and bits above IRQ_CNT are dropped
        end
    end

    // writing ID n pulses source n; 0 and IDs above IRQ_CNT pulse nothing
    always_comb begin
        ack_next = '0;
        if (wr_en && (ofs == PLIC_ID_ADDR)) begin
            for (int i = 0; i < IRQ_CNT; i++) begin
                if (wr_id == irq_id_t'(i + 1)) begin
                    ack_next[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iack_o <= '0;
        end else begin
            iack_o <= ack_next;                        // high for exactly the cycle after the write
        end
    end

endmodule

`default_nettype wire

/* hdl/irq_timer.sv */
// a disabled channel keeps loading its reload value, so it always starts from the full count
`timescale 1ns/10ps
`default_nettype none

module irq_timer
    import bus_pkg::*, irq_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_n,

    input  wire bus_req_t              bus_i,          // already gated by the decoder
    output logic [BUS_DATA_W-1:0]      rdata_o,        // registered read data

    output logic [TMR_CH_CNT-1:0]      irq_o,          // level per channel
    input  wire logic [TMR_CH_CNT-1:0] iack_i          // acknowledge pulse per channel
);

    logic [TMR_CH_CNT-1:0] ctrl_q;                     // channel enables
    logic [BUS_DATA_W-1:0] reload_q [TMR_CH_CNT];      // start values
    logic [BUS_DATA_W-1:0] count_q [TMR_CH_CNT];       // down-counters
    logic [TMR_CH_CNT-1:0] flag_q;                     // expired and not yet acknowledged

    tmr_reg_e              reg_sel;                    // addressed register
    logic                  rd_en;
    logic                  wr_en;
    logic [BUS_DATA_W-1:0] reg_val;                    // addressed register, zero extended
    logic [BUS_DATA_W-1:0] write_val;                  // reg_val with the written bytes merged

    assign reg_sel   = tmr_reg_e'(bus_i.addr[PERIPH_OFS_W-1:0]);
    assign rd_en     = bus_i.en && (bus_i.we == '0);
    assign wr_en     = bus_i.en && (bus_i.we != '0);
    assign write_val = be_merge(reg_val, bus_i.wdata, bus_i.we);

    always_comb begin
        unique case (reg_sel)
            TMR_CTRL:    reg_val = {{(BUS_DATA_W - TMR_CH_CNT){1'b0}}, ctrl_q};
            TMR_RELOAD0: reg_val = reload_q[0];
            TMR_RELOAD1: reg_val = reload_q[1];
            TMR_COUNT0:  reg_val = count_q[0];
            TMR_COUNT1:  reg_val = count_q[1];
            default:     reg_val = '0;                 // holes in the map read as zero
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata_o <= '0;
        end else if (rd_en) begin
            rdata_o <= reg_val;
        end
    end

    // counter registers ignore writes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q      <= '0;
            reload_q[0] <= '0;
            reload_q[1] <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                TMR_CTRL:    ctrl_q      <= write_val[TMR_CH_CNT-1:0];
                TMR_RELOAD0: reload_q[0] <= write_val;
                TMR_RELOAD1: reload_q[1] <= write_val;
                default:     ;
            endcase
        end
    end

    // counts R, R-1 .. 0, then holds at 0 with the flag up
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int c = 0; c < TMR_CH_CNT; c++) begin
                count_q[c] <= '0;
                flag_q[c]  <= 1'b0;
            end
        end else begin
            for (int c = 0; c < TMR_CH_CNT; c++) begin
                if (!ctrl_q[c] || iack_i[c]) begin
                    count_q[c] <= reload_q[c];         // restart from the reload value
                    flag_q[c]  <= 1'b0;                // level drops with the acknowledge
                end else if (count_q[c] == '0) begin
                    flag_q[c]  <= 1'b1;                // fire and wait for the acknowledge
                end else begin
                    count_q[c] <= count_q[c] - 1'b1;
                end
            end
        end
    end

    assign irq_o = flag_q;

endmodule

`default_nettype wire

/* hdl/periph_top.sv */
// source 1 and 2 are the timer, 3 and 4 the external pins; iack_i must be a single-cycle pulse
`timescale 1ns/10ps
`default_nettype none

module periph_top
    import bus_pkg::*, irq_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    input  wire bus_req_t               bus_i,         // peripheral bus request
    input  wire logic [EXT_IRQ_CNT-1:0] ext_irq_i,     // external levels, sources 3 and 4
    input  wire logic                   iack_i,        // claim pulse from the core

    output logic [BUS_DATA_W-1:0]       rdata_o,       // read data, one cycle after the strobe
    output logic                        irq_o,         // interrupt level to the core
    output logic [EXT_IRQ_CNT-1:0]      ext_iack_o     // acknowledge pulses for sources 3 and 4
);

    bus_req_t              plic_bus;                   // request into the controller
    bus_req_t              tmr_bus;                    // request into the timer
    logic [BUS_DATA_W-1:0] plic_rdata;
    logic [BUS_DATA_W-1:0] tmr_rdata;
    logic [TMR_CH_CNT-1:0] tmr_irq;                    // timer levels
    logic [TMR_CH_CNT-1:0] tmr_iack;                   // timer acknowledges
    logic [IRQ_CNT-1:0]    irq_src;                    // all sources, bit 0 is source 1
    logic [IRQ_CNT-1:0]    irq_ack;                    // all acknowledges, bit 0 is source 1

    assign irq_src    = {ext_irq_i, tmr_irq};          // timer takes the low source numbers
    assign tmr_iack   = irq_ack[int'(TMR_IRQ_BASE) - 1 +: TMR_CH_CNT];
    assign ext_iack_o = irq_ack[IRQ_CNT-1 -: EXT_IRQ_CNT];

    periph_decoder decoder_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .bus_i        (bus_i),
        .plic_bus_o   (plic_bus),
        .tmr_bus_o    (tmr_bus),
        .plic_rdata_i (plic_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .rdata_o      (rdata_o)
    );

    plic plic_i (
        .clk     (clk),
        .reset_n (reset_n),
        .bus_i   (plic_bus),
        .rdata_o (plic_rdata),
        .irq_i   (irq_src),
        .iack_i  (iack_i),
        .iack_o  (irq_ack),
        .irq_o   (irq_o)
    );

    irq_timer timer_i (
        .clk     (clk),
        .reset_n (reset_n),
        .bus_i   (tmr_bus),
        .rdata_o (tmr_rdata),
        .irq_o   (tmr_irq),
        .iack_i  (tmr_iack)
    );

endmodule

`default_nettype wire

/* tests/tb_periph.sv */
// drives one bus request at a time from a single initial block; timer checks allow a few cycles of slack
`timescale 1ns/10ps
`default_nettype none

module tb_periph
    import bus_pkg::*, irq_pkg::*;
;

    logic        clk;
    logic        reset_n;
    bus_req_t    bus;                                  // request into the DUT
    logic [1:0]  ext_irq;                              // external levels, sources 3 and 4
    logic        iack;                                 // claim pulse from the core side
    logic [31:0] rdata;
    logic        irq;
    logic [1:0]  ext_iack;

    int          error_count;                          // failed checks and timeouts
    int          errors_at_start;                      // error_count when the current test began
    int          tests_passed;
    int          tests_failed;
    int          test_no;
    logic [31:0] rng_state;

    periph_top dut_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus_i      (bus),
        .ext_irq_i  (ext_irq),
        .iack_i     (iack),
        .rdata_o    (rdata),
        .irq_o      (irq),
        .ext_iack_o (ext_iack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                        // 100 ns period
    end

    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];                       // the low bits of an LCG repeat quickly
    endfunction

    function automatic logic [BUS_ADDR_W-1:0] addr_of(input periph_sel_e sel,
                                                      input logic [23:0] ofs);
        case (sel)
            SEL_PLIC:  return {PERIPH_PLIC_BASE, ofs};
            SEL_TIMER: return {PERIPH_TIMER_BASE, ofs};
            default:   return {4'hF, ofs};             // nothing lives in the top window
        endcase
    endfunction

    // enabled bytes come from data and the other bytes keep their value
    function automatic logic [31:0] merge_bytes(input logic [31:0] cur, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic bus_write(input periph_sel_e sel, input logic [23:0] ofs,
                             input logic [31:0] data, input logic [3:0] be);
        @(posedge clk);
        bus.en    <= 1'b1;
        bus.we    <= be;
        bus.addr  <= addr_of(sel, ofs);
        bus.wdata <= data;
        @(posedge clk);                                // DUT takes the strobe on this edge
        bus.en    <= 1'b0;
        bus.we    <= '0;
    endtask

    task automatic bus_read(input periph_sel_e sel, input logic [23:0] ofs, output logic [31:0] data);
        @(posedge clk);
        bus.en   <= 1'b1;
        bus.we   <= '0;
        bus.addr <= addr_of(sel, ofs);
        @(posedge clk);
        bus.en   <= 1'b0;
        @(negedge clk);                                // rdata_o is settled one cycle after the strobe
        data = rdata;
    endtask

    task automatic claim_pulse();
        @(posedge clk);
        iack <= 1'b1;
        @(posedge clk);                                // ID is latched on this edge
        iack <= 1'b0;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_irq(input logic level, input int limit, input string what);
        int n;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (irq === level) break;
        end
        if (n == limit) begin
            $display("timeout: irq_o did not go to %0b within %0d cycles (%s)",
                     level, limit, what);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_no++;
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: passed", test_no, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors",
                     test_no, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] ie_val;
        logic [31:0] exp;
        logic [31:0] reload;
        logic [15:0] r16;
        logic [3:0]  be;
        logic [3:0]  pat;
        rng_state = 32'd58;
        error_count = 0;
        errors_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_no = 0;
        reset_n = 1'b0;
        bus = '0;
        ext_irq = '0;
        iack = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        check_equal({31'h0, irq}, 0, "irq_o after reset");
        check_equal({30'h0, ext_iack}, 0, "ext_iack_o after reset");
        bus_read(SEL_PLIC, PLIC_IE_ADDR, data);
        check_equal(data, 0, "IE after reset");
        bus_read(SEL_PLIC, PLIC_IP_ADDR, data);
        check_equal(data, 0, "IP after reset");
        bus_read(SEL_PLIC, PLIC_ID_ADDR, data);
        check_equal(data, 0, "claim ID after reset");
        bus_read(SEL_TIMER, TMR_CTRL, data);
        check_equal(data, 0, "timer control after reset");
        report_test("reset values");

        ie_val = '0;
        for (int i = 0; i < 8; i++) begin
            data = {next_rand(), next_rand()};
            r16 = next_rand();
            be = r16[3:0];
            if (be == 4'h0) be = 4'h1;                 // no enables at all would be a read
            bus_write(SEL_PLIC, PLIC_IE_ADDR, data, be);
            ie_val = merge_bytes(ie_val, data, be) & 32'h1E;  // only sources 1 to 4 exist
            bus_read(SEL_PLIC, PLIC_IE_ADDR, data);
            check_equal(data, ie_val, "IE after byte-enabled write");
        end
        bus_write(SEL_PLIC, PLIC_IE_ADDR, 32'h1E, 4'h1);
        ie_val = 32'h1E;                               // leaves nonzero read data in the controller
        bus_read(SEL_PLIC, PLIC_IE_ADDR, data);
        check_equal(data, ie_val, "IE with every source enabled");
        bus_read(SEL_NONE, 24'h000000, data);
        check_equal(data, 0, "unmapped peripheral window");
        bus_read(SEL_PLIC, 24'h000100, data);
        check_equal(data, 0, "unmapped controller offset");
        report_test("byte-enabled IE writes");

        @(posedge clk);
        ext_irq <= 2'b11;
        repeat (2) @(posedge clk);                     // ip trails the levels by one cycle
        bus_read(SEL_PLIC, PLIC_IP_ADDR, data);
        check_equal(data, 32'h18, "IP with both external lines high");
        for (int i = 0; i < 6; i++) begin
            r16 = next_rand();
            pat = (i == 0) ? 4'h0 : r16[3:0];          // first pass masks everything
            bus_write(SEL_PLIC, PLIC_IE_ADDR, {27'h0, pat, 1'b0}, 4'hF);
            claim_pulse();
            bus_read(SEL_PLIC, PLIC_ID_ADDR, data);
            exp = 0;
            for (int n = 4; n >= 3; n--) begin
                if (pat[n-1]) exp = n;                 // only 3 and 4 pend, lower number wins
            end
            check_equal(data, exp, "claimed ID for IE subset");
            check_equal({31'h0, irq}, {31'h0, exp != 0}, "irq_o against enabled pending");
            if (pat == 4'h0) begin
                repeat (4) begin
                    @(negedge clk);
                    check_equal({31'h0, irq}, 0, "irq_o with IE zero");
                end
            end
        end
        report_test("priority and claim");

        for (int id = 3; id <= 4; id++) begin
            @(negedge clk);
            check_equal({30'h0, ext_iack}, 0, "ext_iack_o before the ID write");
            bus_write(SEL_PLIC, PLIC_ID_ADDR, id, 4'hF);
            for (int c = 0; c < 5; c++) begin
                @(negedge clk);
                exp = (c == 0) ? (32'h1 << (id - 3)) : 32'h0;
                check_equal({30'h0, ext_iack}, exp, "ext_iack_o around the ID write");
            end
        end
        @(posedge clk);
        ext_irq <= 2'b00;
        report_test("acknowledge pulse");

        for (int ch = 0; ch < 2; ch++) begin
            r16 = next_rand();
            reload = 32'd8 + r16 % 33;                 // 8 to 40 cycles
            bus_write(SEL_PLIC, PLIC_IE_ADDR, 32'h1 << (ch + 1), 4'hF);
            bus_write(SEL_TIMER, ch ? TMR_RELOAD1 : TMR_RELOAD0, reload, 4'hF);
            bus_write(SEL_TIMER, TMR_CTRL, 32'h1 << ch, 4'hF);
            wait_irq(1'b1, reload + 10, "timer expiry");
            claim_pulse();
            bus_read(SEL_PLIC, PLIC_ID_ADDR, data);
            check_equal(data, ch + 1, "claimed timer ID");
            bus_write(SEL_PLIC, PLIC_ID_ADDR, ch + 1, 4'hF);
            wait_irq(1'b0, 3, "timer acknowledge");
            bus_read(SEL_TIMER, ch ? TMR_COUNT1 : TMR_COUNT0, data);
            assert (data <= reload && data + 4 >= reload) else begin
                $display("error at %0t ns: count 0x%0h not just below reload 0x%0h",
                         $time, data, reload);
                error_count++;
            end
            bus_write(SEL_TIMER, TMR_CTRL, 0, 4'hF);   // stop the channel before the next one
        end
        report_test("timer interrupt");

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/bus_pkg.sv
common/irq_pkg.sv
hdl/periph_decoder.sv
plic/plic.sv
hdl/irq_timer.sv
hdl/periph_top.sv
tests/tb_periph.sv

/* run_sim.sh */
#!/bin/sh
# builds with Verilator, runs the testbench and checks its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph -f project.f \
    -o tb_periph > build.log 2>&1 \
    && ./obj_dir/tb_periph > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log"; echo "TEST FAILED"; } >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
